// File: src/dma_pkg.sv
/*
 * Shared constants and the control state type for the AXI copy engine.
 * Every RTL block imports what it needs from here; the top level passes
 * the address width and FIFO depth down as module parameters.
 */
package dma_pkg;

    // Data beat geometry
    localparam int DATA_W     = 32;
    localparam int BEAT_BYTES = DATA_W / 8;
    localparam int BEAT_BW    = $clog2(BEAT_BYTES);

    // Data FIFO capacity
    localparam int FIFO_BYTES = 128;
    localparam int FIFO_WORDS = FIFO_BYTES / BEAT_BYTES;

    // Half the FIFO but never past the AXI 4 KiB boundary
    localparam int MAX_BLOCK_BYTES = (FIFO_BYTES / 2 < 4096) ? FIFO_BYTES / 2 : 4096;
    localparam int unsigned MAX_XFER_BYTES = 32'h0010_0000;

    // Burst length and byte counter widths
    localparam int LEN_W = 13;
    localparam int CNT_W = 32;

    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
    localparam logic [1:0] AXI_RESP_DECERR = 2'b11;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        DONE,
        ERROR
    } dma_state_e;

endpackage

// File: src/dma_cmd_check.sv
/*
 * Command validation for the copy engine.
 * Purely combinational; the FSM samples cmd_error_o with the go pulse
 * and moves to ERROR instead of WAIT_DATA when it is set.
 */
`timescale 1ns/100ps

module dma_cmd_check #(
    parameter int ADDR_W = 32
) (
    input  logic [ADDR_W-1:0]         src_addr_i,
    input  logic [ADDR_W-1:0]         dst_addr_i,
    input  logic [dma_pkg::CNT_W-1:0] byte_count_i,
    input  logic [dma_pkg::CNT_W-1:0] block_size_i,
    output logic                      cmd_error_o
);
    import dma_pkg::*;

    logic inv_src_addr;
    logic inv_dst_addr;
    logic inv_byte_count;
    logic inv_block_size;

    always_comb begin
        // Both ends must be word aligned
        inv_src_addr = |src_addr_i[BEAT_BW-1:0];
        inv_dst_addr = |dst_addr_i[BEAT_BW-1:0];

        inv_byte_count = (byte_count_i == '0) ||
                         (|byte_count_i[BEAT_BW-1:0]) ||
                         (byte_count_i > MAX_XFER_BYTES);

        // Zero passes the power-of-two test and selects the max block
        inv_block_size = (|(block_size_i & (block_size_i - 1'b1))) ||
                         (|block_size_i[BEAT_BW-1:0]);
    end

    assign cmd_error_o = inv_src_addr   ||
                         inv_dst_addr   ||
                         inv_byte_count ||
                         inv_block_size;

endmodule

// File: src/dma_req_gen.sv
/*
 * One AXI request channel of the copy engine.
 * Walks the transfer from base_addr_i, splitting bursts at block
 * boundaries, and only issues a burst when the credit counter covers
 * its beat count. Used once for reads and once for writes.
 */
`timescale 1ns/100ps

module dma_req_gen #(
    parameter int ADDR_W      = 32,
    parameter int FIFO_DEPTH  = dma_pkg::FIFO_WORDS,
    parameter int CREDIT_INIT = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      active_i,
    input  logic                      clear_i,
    input  logic [ADDR_W-1:0]         base_addr_i,
    input  logic [dma_pkg::CNT_W-1:0] byte_count_i,
    input  logic [dma_pkg::CNT_W-1:0] block_size_i,
    input  logic                      credit_inc_i,
    output logic                      req_valid_o,
    output logic [ADDR_W-1:0]         req_addr_o,
    output logic [dma_pkg::LEN_W-1:0] req_len_o,
    input  logic                      req_ready_i
);
    import dma_pkg::*;

    localparam int CR_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] bytes_req;
    logic [CNT_W-1:0] bytes_left;
    logic [LEN_W-1:0] blk_bytes;
    logic [LEN_W-1:0] blk_offset;
    logic [LEN_W-1:0] align_bytes;
    logic [LEN_W-1:0] burst_bytes;
    logic [LEN_W-1:0] burst_beats;
    logic [CR_W-1:0]  credits;
    logic [CR_W-1:0]  credit_dec;
    logic             accept;

    // Zero or oversized block size falls back to the largest burst
    always_comb begin
        if ((block_size_i == '0) || (block_size_i > CNT_W'(MAX_BLOCK_BYTES))) begin
            blk_bytes = LEN_W'(MAX_BLOCK_BYTES);
        end else begin
            blk_bytes = block_size_i[LEN_W-1:0];
        end
    end

    always_comb begin
        req_addr_o  = base_addr_i + ADDR_W'(bytes_req);
        blk_offset  = req_addr_o[LEN_W-1:0] & (blk_bytes - 1'b1);
        align_bytes = blk_bytes - blk_offset;
        bytes_left  = byte_count_i - bytes_req;
        // Last burst may be shorter than the distance to the boundary
        burst_bytes = (bytes_left < CNT_W'(align_bytes)) ? bytes_left[LEN_W-1:0] : align_bytes;
        burst_beats = burst_bytes >> BEAT_BW;
        req_len_o   = burst_bytes - LEN_W'(BEAT_BYTES);
    end

    assign req_valid_o = active_i &&
                         (bytes_req < byte_count_i) &&
                         (LEN_W'(credits) >= burst_beats);
    assign accept      = req_valid_o && req_ready_i;
    assign credit_dec  = accept ? burst_beats[CR_W-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bytes_req <= '0;
        end else if (clear_i) begin
            bytes_req <= '0;
        end else if (accept) begin
            bytes_req <= bytes_req + CNT_W'(burst_bytes);
        end
    end

    // Read side starts full and refills on pops; write side fills on pushes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CR_W'(CREDIT_INIT);
        end else if (clear_i) begin
            credits <= CR_W'(CREDIT_INIT);
        end else begin
            credits <= credits + CR_W'(credit_inc_i) - credit_dec;
        end
    end

    // First and last byte of an accepted burst share one block
    a_no_block_cross: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (((req_addr_o ^ (req_addr_o + ADDR_W'(req_len_o))) &
                     ~ADDR_W'(blk_bytes - 1'b1)) == '0))
        else $error("burst crosses block boundary at %h", req_addr_o);

    // Holds only if the FIFO returns no more credits than were taken
    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= FIFO_DEPTH)
        else $error("credit count %0d above FIFO depth", credits);

endmodule

// File: src/dma_data_fifo.sv
/*
 * Synchronous data FIFO between the AXI read and write data channels.
 * Valid/ready on both sides, one cycle from push to pop, zero data
 * when empty. clear_i drops all content.
 */
`timescale 1ns/100ps

module dma_data_fifo #(
    parameter int FIFO_DEPTH = dma_pkg::FIFO_WORDS
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear_i,
    input  logic                        push_valid_i,
    output logic                        push_ready_o,
    input  logic [dma_pkg::DATA_W-1:0]  push_data_i,
    output logic                        pop_valid_o,
    input  logic                        pop_ready_i,
    output logic [dma_pkg::DATA_W-1:0]  pop_data_o,
    output logic [$clog2(FIFO_DEPTH):0] depth_o
);
    import dma_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [DATA_W-1:0]         mem [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic                      push;
    logic                      pop;

    // Wrap explicitly so non power-of-two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count != FIFO_DEPTH);
    assign pop_valid_o  = (count != '0);
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;
    assign pop_data_o   = pop_valid_o ? mem[rd_ptr] : '0;
    assign depth_o      = count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + push - pop;
        end
    end

    a_depth_limit: assert property (@(posedge clk) disable iff (!rst_n)
        count <= FIFO_DEPTH)
        else $error("FIFO occupancy %0d above depth", count);

endmodule

// File: src/dma_ctrl_fsm.sv
/*
 * Control state machine of the copy engine.
 * Tracks bytes still to reach the destination, outstanding write
 * responses and a sticky AXI error, and drives the status outputs.
 */
`timescale 1ns/100ps

module dma_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go_i,
    input  logic                      cmd_error_i,
    input  logic                      flush_i,
    input  logic [dma_pkg::CNT_W-1:0] byte_count_i,
    input  logic                      beat_done_i,
    input  logic                      wr_req_accept_i,
    input  logic                      rd_resp_valid_i,
    input  logic [1:0]                rd_resp_i,
    input  logic                      wr_resp_valid_i,
    input  logic [1:0]                wr_resp_i,
    output dma_pkg::dma_state_e       state_o,
    output logic                      wr_stall_o,
    output logic                      done_o,
    output logic                      busy_o,
    output logic                      error_o
);
    import dma_pkg::*;

    dma_state_e       state_q;
    dma_state_e       state_d;
    logic [CNT_W-1:0] bytes_remaining;
    logic [3:0]       wr_pending;
    logic             axi_error;
    logic             resp_error;
    logic             drained;

    assign resp_error = (rd_resp_valid_i && (rd_resp_i inside {AXI_RESP_SLVERR, AXI_RESP_DECERR})) ||
                        (wr_resp_valid_i && (wr_resp_i inside {AXI_RESP_SLVERR, AXI_RESP_DECERR}));
    assign drained    = (bytes_remaining == '0) && (wr_pending == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (go_i) begin
                    state_d = cmd_error_i ? ERROR : WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (drained) begin
                    state_d = axi_error ? ERROR : DONE;
                end
            end
            DONE:    state_d = IDLE;
            ERROR: begin
                if (flush_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts down as beats leave toward the destination
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bytes_remaining <= '0;
        end else if ((state_q == IDLE) && go_i) begin
            bytes_remaining <= byte_count_i;
        end else if (beat_done_i) begin
            bytes_remaining <= bytes_remaining - CNT_W'(BEAT_BYTES);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pending <= '0;
        end else if (state_q == IDLE) begin
            wr_pending <= '0;
        end else if (wr_req_accept_i && !wr_resp_valid_i) begin
            wr_pending <= wr_pending + 1'b1;
        end else if (!wr_req_accept_i && wr_resp_valid_i) begin
            wr_pending <= wr_pending - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_error <= 1'b0;
        end else if ((state_q == IDLE) || flush_i) begin
            axi_error <= 1'b0;
        end else if (resp_error) begin
            axi_error <= 1'b1;
        end
    end

    assign state_o    = state_q;
    assign wr_stall_o = (wr_pending == 4'hf);
    assign done_o     = (state_q == DONE);
    assign busy_o     = (state_q != IDLE);
    assign error_o    = (state_q == ERROR);

    // Top level must hold off write requests once the counter saturates
    a_pending_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        wr_stall_o |-> !wr_req_accept_i)
        else $error("write request accepted with 15 responses pending");

endmodule

// File: src/axi_dma_ctrl.sv
/*
 * Top level of the AXI copy engine controller.
 * Command checker, control FSM, read and write request channels and
 * the data FIFO; the AXI side is exposed as loose valid/ready ports.
 */
`timescale 1ns/100ps

module axi_dma_ctrl #(
    parameter int ADDR_W     = 32,
    parameter int FIFO_DEPTH = dma_pkg::FIFO_WORDS
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Command and status
    input  logic                       go_i,
    input  logic [ADDR_W-1:0]          src_addr_i,
    input  logic [ADDR_W-1:0]          dst_addr_i,
    input  logic [dma_pkg::CNT_W-1:0]  byte_count_i,
    input  logic [dma_pkg::CNT_W-1:0]  block_size_i,
    input  logic                       flush_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       error_o,
    // Read request and response
    output logic                       rd_req_valid_o,
    output logic [ADDR_W-1:0]          rd_req_addr_o,
    output logic [dma_pkg::LEN_W-1:0]  rd_req_len_o,
    input  logic                       rd_req_ready_i,
    input  logic                       rd_resp_valid_i,
    input  logic [1:0]                 rd_resp_i,
    // Write request and response
    output logic                       wr_req_valid_o,
    output logic [ADDR_W-1:0]          wr_req_addr_o,
    output logic [dma_pkg::LEN_W-1:0]  wr_req_len_o,
    input  logic                       wr_req_ready_i,
    input  logic                       wr_resp_valid_i,
    input  logic [1:0]                 wr_resp_i,
    // Data channels
    input  logic                       r_valid_i,
    input  logic [dma_pkg::DATA_W-1:0] r_data_i,
    output logic                       r_ready_o,
    output logic                       w_valid_o,
    output logic [dma_pkg::DATA_W-1:0] w_data_o,
    input  logic                       w_ready_i
);
    import dma_pkg::*;

    dma_state_e                  state;
    logic                        cmd_error;
    logic                        wr_stall;
    logic                        in_idle;
    logic                        in_wait;
    logic                        fifo_push;
    logic                        fifo_pop;
    logic                        wr_req_accept;
    logic [$clog2(FIFO_DEPTH):0] fifo_depth;

    assign in_idle       = (state == IDLE);
    assign in_wait       = (state == WAIT_DATA);
    assign fifo_push     = r_valid_i && r_ready_o;
    assign fifo_pop      = w_valid_o && w_ready_i;
    assign wr_req_accept = wr_req_valid_o && wr_req_ready_i;

    dma_cmd_check #(.ADDR_W(ADDR_W)) u_cmd_check (
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .byte_count_i (byte_count_i),
        .block_size_i (block_size_i),
        .cmd_error_o  (cmd_error)
    );

    dma_ctrl_fsm u_ctrl_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .go_i            (go_i),
        .cmd_error_i     (cmd_error),
        .flush_i         (flush_i),
        .byte_count_i    (byte_count_i),
        .beat_done_i     (fifo_pop),
        .wr_req_accept_i (wr_req_accept),
        .rd_resp_valid_i (rd_resp_valid_i),
        .rd_resp_i       (rd_resp_i),
        .wr_resp_valid_i (wr_resp_valid_i),
        .wr_resp_i       (wr_resp_i),
        .state_o         (state),
        .wr_stall_o      (wr_stall),
        .done_o          (done_o),
        .busy_o          (busy_o),
        .error_o         (error_o)
    );

    // Read credits come back as beats leave the FIFO
    dma_req_gen #(
        .ADDR_W      (ADDR_W),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .CREDIT_INIT (FIFO_DEPTH)
    ) u_rd_req (
        .clk          (clk),
        .rst_n        (rst_n),
        .active_i     (in_wait),
        .clear_i      (in_idle),
        .base_addr_i  (src_addr_i),
        .byte_count_i (byte_count_i),
        .block_size_i (block_size_i),
        .credit_inc_i (fifo_pop),
        .req_valid_o  (rd_req_valid_o),
        .req_addr_o   (rd_req_addr_o),
        .req_len_o    (rd_req_len_o),
        .req_ready_i  (rd_req_ready_i)
    );

    // Write credits track beats already buffered
    dma_req_gen #(
        .ADDR_W      (ADDR_W),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .CREDIT_INIT (0)
    ) u_wr_req (
        .clk          (clk),
        .rst_n        (rst_n),
        .active_i     (in_wait && !wr_stall),
        .clear_i      (in_idle),
        .base_addr_i  (dst_addr_i),
        .byte_count_i (byte_count_i),
        .block_size_i (block_size_i),
        .credit_inc_i (fifo_push),
        .req_valid_o  (wr_req_valid_o),
        .req_addr_o   (wr_req_addr_o),
        .req_len_o    (wr_req_len_o),
        .req_ready_i  (wr_req_ready_i)
    );

    dma_data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_data_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (in_idle),
        .push_valid_i (r_valid_i),
        .push_ready_o (r_ready_o),
        .push_data_i  (r_data_i),
        .pop_valid_o  (w_valid_o),
        .pop_ready_i  (w_ready_i),
        .pop_data_o   (w_data_o),
        .depth_o      (fifo_depth)
    );

    // Every buffered beat has left by the time the copy reports done
    a_done_drained: assert property (@(posedge clk) disable iff (!rst_n)
        (state == DONE) |-> (fifo_depth == '0))
        else $error("done with %0d beats left in FIFO", fifo_depth);

endmodule

// File: verification/axi_dma_ctrl_tb.sv
/*
 * Testbench for the AXI copy engine controller.
 * Commands and expected outcomes come from verification/dma_patterns.txt.
 * A simple AXI memory model answers the request and data ports; the
 * bench checks request addresses and lengths, write data order and the
 * final status of every command.
 */
`timescale 1ns/100ps

module axi_dma_ctrl_tb;
    import dma_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam int          NUM_PAT    = 14;
    localparam int          PAT_COLS   = 6;
    localparam logic [31:0] SEED       = 32'ha20cf001;
    localparam logic [31:0] DATA_MASK  = 32'h5a5a0000;

    logic              clk;
    logic              rst_n;
    logic              go_i;
    logic [31:0]       src_addr_i;
    logic [31:0]       dst_addr_i;
    logic [CNT_W-1:0]  byte_count_i;
    logic [CNT_W-1:0]  block_size_i;
    logic              flush_i;
    logic              busy_o;
    logic              done_o;
    logic              error_o;
    logic              rd_req_valid_o;
    logic [31:0]       rd_req_addr_o;
    logic [LEN_W-1:0]  rd_req_len_o;
    logic              rd_req_ready_i;
    logic              rd_resp_valid_i;
    logic [1:0]        rd_resp_i;
    logic              wr_req_valid_o;
    logic [31:0]       wr_req_addr_o;
    logic [LEN_W-1:0]  wr_req_len_o;
    logic              wr_req_ready_i;
    logic              wr_resp_valid_i;
    logic [1:0]        wr_resp_i;
    logic              r_valid_i;
    logic [DATA_W-1:0] r_data_i;
    logic              r_ready_o;
    logic              w_valid_o;
    logic [DATA_W-1:0] w_data_o;
    logic              w_ready_i;

    logic [31:0] pat_mem [NUM_PAT*PAT_COLS];
    logic [31:0] rand_state;
    logic        cur_inject;
    logic [31:0] rd_bytes;
    logic [31:0] wr_bytes;
    logic [31:0] popped_bytes;
    logic [31:0] rd_beats [$];
    logic [31:0] wr_ends [$];
    int          req_count;
    int          beat_total;
    int          errors;
    int          cycles;
    int          cycle_limit;

    axi_dma_ctrl u_axi_dma_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stops making progress
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no end of run after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Expected length field of the next burst cut at the block end
    function automatic logic [LEN_W-1:0] split_len(input logic [31:0] addr,
                                                   input logic [31:0] left,
                                                   input logic [31:0] blk);
        logic [31:0] span;
        logic [31:0] room;
        logic [31:0] bytes;
        if ((blk == 0) || (blk > MAX_BLOCK_BYTES)) begin
            span = MAX_BLOCK_BYTES;
        end else begin
            span = blk;
        end
        room  = span - (addr % span);
        bytes = (left < room) ? left : room;
        return LEN_W'(bytes - BEAT_BYTES);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input int idx, input string what);
        $display("Pattern %0d: %s", idx, what);
        errors++;
    endtask

    // One clock of the AXI memory model driven at the falling edge
    task automatic step_axi();
        logic [31:0]      rnd;
        logic [31:0]      exp_data;
        logic [31:0]      exp_addr;
        logic [LEN_W-1:0] exp_len;
        int               i;
        @(negedge clk);
        rnd = next_rand();
        // Write response one edge after the last beat of its burst
        wr_resp_valid_i = 1'b0;
        wr_resp_i       = 2'b00;
        if ((wr_ends.size() != 0) && (popped_bytes >= wr_ends[0])) begin
            wr_resp_valid_i = 1'b1;
            wr_resp_i       = cur_inject ? AXI_RESP_SLVERR : 2'b00;
            void'(wr_ends.pop_front());
        end
        r_valid_i = (rd_beats.size() != 0);
        r_data_i  = r_valid_i ? rd_beats[0] : '0;
        if (r_valid_i && r_ready_o) begin
            void'(rd_beats.pop_front());
        end
        // Only beats covered by accepted write requests are taken
        w_ready_i = (popped_bytes < wr_bytes) && (|rnd[21:20]);
        if (w_valid_o && w_ready_i) begin
            exp_data = ((src_addr_i + popped_bytes) >> 2) ^ DATA_MASK;
            if (w_data_o !== exp_data) begin
                report_mismatch("w_data_o", w_data_o, exp_data);
            end
            popped_bytes = popped_bytes + BEAT_BYTES;
            beat_total++;
        end
        rd_req_ready_i = |rnd[17:16];
        if (rd_req_valid_o && rd_req_ready_i) begin
            exp_addr = src_addr_i + rd_bytes;
            exp_len  = split_len(exp_addr, byte_count_i - rd_bytes, block_size_i);
            if (rd_req_addr_o !== exp_addr) begin
                report_mismatch("rd_req_addr_o", rd_req_addr_o, exp_addr);
            end
            if (rd_req_len_o !== exp_len) begin
                report_mismatch("rd_req_len_o", rd_req_len_o, exp_len);
            end
            for (i = 0; i <= rd_req_len_o; i += BEAT_BYTES) begin
                rd_beats.push_back(((rd_req_addr_o + i) >> 2) ^ DATA_MASK);
            end
            rd_bytes = rd_bytes + exp_len + BEAT_BYTES;
            req_count++;
        end
        wr_req_ready_i = |rnd[19:18];
        if (wr_req_valid_o && wr_req_ready_i) begin
            exp_addr = dst_addr_i + wr_bytes;
            exp_len  = split_len(exp_addr, byte_count_i - wr_bytes, block_size_i);
            if (wr_req_addr_o !== exp_addr) begin
                report_mismatch("wr_req_addr_o", wr_req_addr_o, exp_addr);
            end
            if (wr_req_len_o !== exp_len) begin
                report_mismatch("wr_req_len_o", wr_req_len_o, exp_len);
            end
            wr_bytes = wr_bytes + exp_len + BEAT_BYTES;
            wr_ends.push_back(wr_bytes);
            req_count++;
        end
    endtask

    task automatic run_pattern(input int idx);
        logic expect_err;
        rd_bytes     = '0;
        wr_bytes     = '0;
        popped_bytes = '0;
        req_count    = 0;
        rd_beats.delete();
        wr_ends.delete();
        src_addr_i   = pat_mem[idx*PAT_COLS];
        dst_addr_i   = pat_mem[idx*PAT_COLS+1];
        byte_count_i = pat_mem[idx*PAT_COLS+2];
        block_size_i = pat_mem[idx*PAT_COLS+3];
        cur_inject   = pat_mem[idx*PAT_COLS+4][0];
        expect_err   = pat_mem[idx*PAT_COLS+5][0];
        go_i = 1'b1;
        step_axi();
        go_i = 1'b0;
        while (!done_o && !error_o) begin
            step_axi();
        end
        if (expect_err) begin
            if (error_o !== 1'b1) begin
                report_mismatch("error_o", error_o, 1'b1);
            end
            if (!cur_inject && (req_count != 0)) begin
                report_problem(idx, "requests were issued for a rejected command");
            end
            flush_i = 1'b1;
            step_axi();
            flush_i = 1'b0;
            if (error_o !== 1'b0) begin
                report_mismatch("error_o", error_o, 1'b0);
            end
        end else begin
            if (error_o !== 1'b0) begin
                report_mismatch("error_o", error_o, 1'b0);
            end
            step_axi();
            if (done_o !== 1'b0) begin
                report_problem(idx, "done_o stayed high for more than one cycle");
            end
        end
        if (busy_o !== 1'b0) begin
            report_mismatch("busy_o", busy_o, 1'b0);
        end
        // Rejected commands move no data at all
        if (cur_inject || !expect_err) begin
            if (popped_bytes !== byte_count_i) begin
                report_mismatch("write byte total", popped_bytes, byte_count_i);
            end
            if (rd_bytes !== byte_count_i) begin
                report_mismatch("read request byte total", rd_bytes, byte_count_i);
            end
        end
    endtask

    initial begin
        int total;
        int p;
        total = 0;
        $readmemh("verification/dma_patterns.txt", pat_mem);
        for (p = 0; p < NUM_PAT; p++) begin
            total += pat_mem[p*PAT_COLS+2];
        end
        cycle_limit     = NUM_PAT * 200 + (total * 2000) / 1024;
        cycles          = 0;
        rand_state      = SEED;
        errors          = 0;
        beat_total      = 0;
        cur_inject      = 1'b0;
        rd_bytes        = '0;
        wr_bytes        = '0;
        popped_bytes    = '0;
        rst_n           = 1'b0;
        go_i            = 1'b0;
        src_addr_i      = '0;
        dst_addr_i      = '0;
        byte_count_i    = '0;
        block_size_i    = '0;
        flush_i         = 1'b0;
        rd_req_ready_i  = 1'b0;
        rd_resp_valid_i = 1'b0;
        rd_resp_i       = 2'b00;
        wr_req_ready_i  = 1'b0;
        wr_resp_valid_i = 1'b0;
        wr_resp_i       = 2'b00;
        r_valid_i       = 1'b0;
        r_data_i        = '0;
        w_ready_i       = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        step_axi();
        // Outputs quiet and FIFO ready before the first command
        if ({rd_req_valid_o, wr_req_valid_o, w_valid_o, busy_o, done_o, error_o, r_ready_o}
            !== 7'b0000001) begin
            report_mismatch(
                "{rd_req_valid_o,wr_req_valid_o,w_valid_o,busy_o,done_o,error_o,r_ready_o}",
                {rd_req_valid_o, wr_req_valid_o, w_valid_o, busy_o, done_o,
                 error_o, r_ready_o}, 7'b0000001);
        end
        for (p = 0; p < NUM_PAT; p++) begin
            run_pattern(p);
        end
        $display("Patterns: %0d, write beats: %0d, errors: %0d", NUM_PAT, beat_total, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: axi_dma_ctrl.f
src/dma_pkg.sv
src/dma_cmd_check.sv
src/dma_req_gen.sv
src/dma_data_fifo.sv
src/dma_ctrl_fsm.sv
src/axi_dma_ctrl.sv
verification/axi_dma_ctrl_tb.sv

// File: verification/dma_patterns.txt
// One command per line, all values in hex
// src_addr dst_addr byte_count block_size inject expect
// inject 1 answers every write burst with SLVERR; expect 0 = done, 1 = error
00001000 00008000 00000040 00000040 0 0
00001004 00008010 00000100 00000020 0 0
00002000 0000a008 00000400 00000000 0 0
0000300c 0000b000 00000804 00000010 0 0
00004000 0000c004 00000004 00000008 0 0
00005010 0000d020 00000200 00000100 0 0
00006002 0000e000 00000040 00000040 0 1
00006000 0000e001 00000040 00000040 0 1
00006000 0000e000 00000040 00000030 0 1
00006000 0000e000 00000000 00000040 0 1
00007000 0000f000 00000180 00000020 1 1
00010000 00020004 00000c00 00000040 0 0
00011008 00021010 00000600 00000004 0 0
00012000 00022000 00000006 00000040 0 1
